// File: src/kd_tree_pkg.sv
// Tree geometry, patch format and query tag width for the KD-tree search engine
package kd_tree_pkg;

  // A patch is a fixed set of signed coordinates packed into one vector
  localparam int num_dims    = 5;  // Dimensions per patch
  localparam int coord_width = 11; // Bits of one signed coordinate

  // Dimension 0 sits in the low bits of the packed patch
  localparam int patch_width = num_dims * coord_width;

  // The tree is balanced, so every query crosses the same number of levels
  localparam int tree_depth = 3;               // Levels of internal nodes
  localparam int num_leaves = 1 << tree_depth; // One leaf per root to bottom path

  // A node or leaf address is the branch history collected so far
  localparam int path_width = tree_depth;

  // Split dimension field, wide enough for every real dimension plus a spare code
  localparam int dim_width = 3;

  // Reset code for a node dimension
  // It selects no coordinate, the slice reads zero and the node sends everything right
  localparam logic [dim_width-1:0] dim_invalid = 3'd7;

  // Sideband carried alongside every query so results can be matched up
  localparam int tag_width = 8;

  // Class label stored per leaf
  localparam int label_width = 8;

endpackage

// File: src/kd_cfg_pkg.sv
// Configuration word layout and the level code of the leaf table
package kd_cfg_pkg;

  // One configuration word programs either a node or a leaf
  localparam int cfg_width = 22;

  // Node words carry the split dimension in the low bits
  localparam int cfg_dim_lsb = 0; // Dimension sits in bits 2 to 0

  // The median fills the top of the word, bits 21 to 11
  localparam int cfg_median_lsb = cfg_width - kd_tree_pkg::coord_width;

  // Leaf words carry only the label, bits 7 to 0
  localparam int cfg_label_lsb = 0;

  // The level selector picks one of the node levels or the leaf table
  localparam int cfg_level_width = 2;

  // Codes 0 to 2 address the node levels by depth
  // This spare code addresses the leaf table instead
  localparam logic [cfg_level_width-1:0] leaf_level = 2'd3;

endpackage

// File: src/kd_query_if.sv
// Query bus between pipeline stages with sender and receiver modports
interface kd_query_if;

  logic                               valid; // Single cycle strobe, one query per cycle
  logic [kd_tree_pkg::patch_width-1:0] patch; // Coordinates, dimension 0 in the low bits
  logic [kd_tree_pkg::path_width-1:0]  path;  // Branches taken so far, newest in bit 0
  logic [kd_tree_pkg::tag_width-1:0]   tag;   // Travels unchanged to the result

  // Upstream stage drives the whole bundle
  modport sender (
    output valid,
    output patch,
    output path,
    output tag
  );

  // Downstream stage only looks at it
  modport receiver (
    input valid,
    input patch,
    input path,
    input tag
  );

endinterface

// File: src/kd_cfg_if.sv
// Configuration write strobe with source and sink modports
interface kd_cfg_if;

  logic                                  wen;   // Single cycle write strobe
  logic [kd_cfg_pkg::cfg_level_width-1:0] level; // Node depth or the leaf table code
  logic [kd_tree_pkg::path_width-1:0]     addr;  // Node index within the level, or leaf number
  logic [kd_cfg_pkg::cfg_width-1:0]       wdata; // Node fields or leaf label

  // Driven from the top level configuration ports
  modport source (
    output wen,
    output level,
    output addr,
    output wdata
  );

  // Every level and the leaf table decode their own writes from it
  modport sink (
    input wen,
    input level,
    input addr,
    input wdata
  );

endinterface

// File: src/internal_node.sv
// KD-tree internal node with split dimension, median and left or right steering
module internal_node (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wen,         // Write strobe already decoded for this node
  input  logic                                valid,       // Query on this node's path
  input  logic [kd_cfg_pkg::cfg_width-1:0]    wdata,
  input  logic [kd_tree_pkg::patch_width-1:0] patch_in,
  output logic                                valid_left,
  output logic                                valid_right
);

  logic        [kd_tree_pkg::dim_width-1:0]   dim;    // Which coordinate this node splits on
  logic signed [kd_tree_pkg::coord_width-1:0] median; // Split point, compared signed
  logic signed [kd_tree_pkg::coord_width-1:0] coord;  // Coordinate pulled out of the patch
  logic                                       go_left;

  // Both fields are loaded together from one configuration word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dim    <= kd_tree_pkg::dim_invalid; // Selects no coordinate until programmed
      median <= '0;
    end else if (wen) begin
      dim    <= wdata[kd_cfg_pkg::cfg_dim_lsb +: kd_tree_pkg::dim_width];
      median <= wdata[kd_cfg_pkg::cfg_median_lsb +: kd_tree_pkg::coord_width];
    end
  end

  // Slice the coordinate named by dim
  // Codes past the last dimension leave the slice at zero
  always_comb begin
    coord = '0;
    for (int d = 0; d < kd_tree_pkg::num_dims; d++) begin
      if (int'(dim) == d) begin
        coord = patch_in[d*kd_tree_pkg::coord_width +: kd_tree_pkg::coord_width];
      end
    end
  end

  // Strictly below the median goes left and a tie goes right
  assign go_left = coord < median;

  assign valid_left  = valid && go_left;
  assign valid_right = valid && !go_left;

endmodule

// File: src/kd_level.sv
// One pipeline stage holding every node of one tree depth and registering the extended path
module kd_level #(
  parameter int level = 0 // Depth served by this stage, 0 is the root
) (
  input  logic         clk,
  input  logic         rst_n,
  kd_cfg_if.sink       cfg,
  kd_query_if.receiver in,
  kd_query_if.sender   out
);

  // Nodes double at every depth
  localparam int num_nodes = 1 << level;

  logic [num_nodes-1:0] node_wen;    // Decoded write strobe per node
  logic [num_nodes-1:0] node_valid;  // Query handed to the node on its path
  logic [num_nodes-1:0] valid_left;
  logic [num_nodes-1:0] valid_right;
  logic                 level_hit;   // Configuration write aimed at this depth
  logic                 branch_right;

  assign level_hit = cfg.wen && (int'(cfg.level) == level);

  for (genvar n = 0; n < num_nodes; n++) begin : g_node
    assign node_wen[n] = level_hit && (int'(cfg.addr) == n);

    // The low path bits name the node this query reached at this depth
    assign node_valid[n] = in.valid && ((int'(in.path) % num_nodes) == n);

    internal_node u_node (
      .clk         (clk),
      .rst_n       (rst_n),
      .wen         (node_wen[n]),
      .valid       (node_valid[n]),
      .wdata       (cfg.wdata),
      .patch_in    (in.patch),
      .valid_left  (valid_left[n]),
      .valid_right (valid_right[n])
    );
  end

  // Only the selected node sees a valid query, so an OR picks its right flag
  assign branch_right = |valid_right;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= in.valid; // No back-pressure, every query advances
    end
  end

  // Payload follows the strobe and is left alone between queries
  always_ff @(posedge clk) begin
    if (in.valid) begin
      out.patch <= in.patch;
      out.tag   <= in.tag;
      out.path  <= {in.path[kd_tree_pkg::path_width-2:0], branch_right}; // Newest branch in bit 0
    end
  end

  // The address must name a node that exists at this depth
  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    level_hit |-> (int'(cfg.addr) < num_nodes))
    else $error("kd_level %0d write to missing node %0d", level, cfg.addr);

  // The path selects exactly one node, so at most one branch fires
  a_one_branch: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({valid_left, valid_right}))
    else $error("kd_level %0d saw more than one node branch", level);

endmodule

// File: src/leaf_table.sv
// Final stage with the leaf label table and the registered search result
module leaf_table (
  input  logic                                clk,
  input  logic                                rst_n,
  kd_cfg_if.sink                              cfg,
  kd_query_if.receiver                        in,
  output logic                                result_valid,
  output logic [kd_tree_pkg::path_width-1:0]  result_leaf,  // Leaf number the query reached
  output logic [kd_tree_pkg::label_width-1:0] result_label,
  output logic [kd_tree_pkg::tag_width-1:0]   result_tag
);

  // One label per leaf, indexed by the full path
  logic [kd_tree_pkg::label_width-1:0] labels [kd_tree_pkg::num_leaves];
  logic                                leaf_wen;

  assign leaf_wen = cfg.wen && (cfg.level == kd_cfg_pkg::leaf_level);

  // Labels come up as zero so an unprogrammed tree still answers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < kd_tree_pkg::num_leaves; i++) begin
        labels[i] <= '0;
      end
    end else if (leaf_wen) begin
      labels[cfg.addr] <= cfg.wdata[kd_cfg_pkg::cfg_label_lsb +: kd_tree_pkg::label_width];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= in.valid;
    end
  end

  // After three levels the path is the leaf number
  always_ff @(posedge clk) begin
    if (in.valid) begin
      result_leaf  <= in.path;
      result_label <= labels[in.path];
      result_tag   <= in.tag; // Lets the host match results to queries
    end
  end

  // The first load out of reset must find the upstream stage empty
  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |=> !result_valid)
    else $error("leaf_table produced a result straight out of reset");

endmodule

// File: src/kd_tree_top.sv
// Top level of the pipelined KD-tree search with three node levels and the leaf table
module kd_tree_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cfg_wen,
  input  logic [kd_cfg_pkg::cfg_level_width-1:0] cfg_level,
  input  logic [kd_tree_pkg::path_width-1:0]     cfg_addr,
  input  logic [kd_cfg_pkg::cfg_width-1:0]       cfg_wdata,
  input  logic                                  query_valid,
  input  logic [kd_tree_pkg::patch_width-1:0]    query_patch,
  input  logic [kd_tree_pkg::tag_width-1:0]      query_tag,
  output logic                                  result_valid,
  output logic [kd_tree_pkg::path_width-1:0]     result_leaf,
  output logic [kd_tree_pkg::label_width-1:0]    result_label,
  output logic [kd_tree_pkg::tag_width-1:0]      result_tag
);

  kd_cfg_if   cfg_bus ();    // Shared by every level and the leaf table
  kd_query_if q_root ();     // Into the root level
  kd_query_if q_level1 ();   // Root to depth 1
  kd_query_if q_level2 ();   // Depth 1 to depth 2
  kd_query_if q_leaf ();     // Depth 2 to the leaf table

  assign cfg_bus.wen   = cfg_wen;
  assign cfg_bus.level = cfg_level;
  assign cfg_bus.addr  = cfg_addr;
  assign cfg_bus.wdata = cfg_wdata;

  // A fresh query has taken no branches yet
  assign q_root.valid = query_valid;
  assign q_root.patch = query_patch;
  assign q_root.path  = '0;
  assign q_root.tag   = query_tag;

  kd_level #(.level(0)) u_level0 (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg_bus.sink),
    .in    (q_root.receiver),
    .out   (q_level1.sender)
  );

  kd_level #(.level(1)) u_level1 (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg_bus.sink),
    .in    (q_level1.receiver),
    .out   (q_level2.sender)
  );

  kd_level #(.level(2)) u_level2 (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg_bus.sink),
    .in    (q_level2.receiver),
    .out   (q_leaf.sender)
  );

  // Fourth register stage, so a result leaves four cycles after its query
  leaf_table u_leaf_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg_bus.sink),
    .in           (q_leaf.receiver),
    .result_valid (result_valid),
    .result_leaf  (result_leaf),
    .result_label (result_label),
    .result_tag   (result_tag)
  );

endmodule

// File: test/kd_tree_tb.sv
// Self-checking testbench for kd_tree_top with stimulus tables, a tree model and random queries
module kd_tree_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [kd_cfg_pkg::cfg_level_width-1:0] level;
    logic [kd_tree_pkg::path_width-1:0]     addr;
    logic [kd_cfg_pkg::cfg_width-1:0]       word;
  } cfg_entry_t;

  typedef struct packed {
    logic [kd_tree_pkg::patch_width-1:0] patch;
    logic [kd_tree_pkg::tag_width-1:0]   tag;
  } query_entry_t;

  typedef struct packed {
    logic [kd_tree_pkg::path_width-1:0]  leaf;
    logic [kd_tree_pkg::label_width-1:0] label;
    logic [kd_tree_pkg::tag_width-1:0]   tag;
    logic [31:0]                         cycle; // Cycle in which the result must show up
  } expected_t;

  localparam int num_cfg     = 15; // 7 nodes and 8 leaves
  localparam int num_queries = 10;
  localparam int drain_limit = 20; // Cycles allowed for the last result to leave

  logic                                   clk = 1'b0;
  logic                                   rst_n;
  logic                                   cfg_wen;
  logic [kd_cfg_pkg::cfg_level_width-1:0] cfg_level;
  logic [kd_tree_pkg::path_width-1:0]     cfg_addr;
  logic [kd_cfg_pkg::cfg_width-1:0]       cfg_wdata;
  logic                                   query_valid;
  logic [kd_tree_pkg::patch_width-1:0]    query_patch;
  logic [kd_tree_pkg::tag_width-1:0]      query_tag;
  logic                                   result_valid;
  logic [kd_tree_pkg::path_width-1:0]     result_leaf;
  logic [kd_tree_pkg::label_width-1:0]    result_label;
  logic [kd_tree_pkg::tag_width-1:0]      result_tag;

  cfg_entry_t   cfg_table   [num_cfg];
  query_entry_t query_table [num_queries];
  expected_t    exp_q [$];
  int           cycle_count = 0;
  int           seed;

  // Software copy of what has been programmed, indexed by depth and node
  logic        [kd_tree_pkg::dim_width-1:0]   model_dim    [kd_tree_pkg::tree_depth][4];
  logic signed [kd_tree_pkg::coord_width-1:0] model_median [kd_tree_pkg::tree_depth][4];
  logic        [kd_tree_pkg::label_width-1:0] model_label  [kd_tree_pkg::num_leaves];

  kd_tree_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wen      (cfg_wen),
    .cfg_level    (cfg_level),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .query_valid  (query_valid),
    .query_patch  (query_patch),
    .query_tag    (query_tag),
    .result_valid (result_valid),
    .result_leaf  (result_leaf),
    .result_label (result_label),
    .result_tag   (result_tag)
  );

  always #5 clk = ~clk; // 10 ns period

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, expected);
      abort_run("a result field did not match the tree model");
    end
  endtask

  // Dimension 0 goes into the low bits
  function automatic logic [kd_tree_pkg::patch_width-1:0] make_patch(
    input int c0, input int c1, input int c2, input int c3, input int c4);
    return {11'(c4), 11'(c3), 11'(c2), 11'(c1), 11'(c0)};
  endfunction

  function automatic logic [kd_tree_pkg::patch_width-1:0] random_patch();
    logic [63:0] raw;
    raw = {$random(seed), $random(seed)};
    return raw[kd_tree_pkg::patch_width-1:0];
  endfunction

  function automatic logic [kd_cfg_pkg::cfg_width-1:0] node_word(input int dim, input int median);
    logic [kd_cfg_pkg::cfg_width-1:0] w;
    w = '0;
    w[kd_cfg_pkg::cfg_dim_lsb +: kd_tree_pkg::dim_width] = 3'(dim);
    w[kd_cfg_pkg::cfg_median_lsb +: kd_tree_pkg::coord_width] = 11'(median);
    return w;
  endfunction

  function automatic logic [kd_cfg_pkg::cfg_width-1:0] leaf_word(input int label);
    logic [kd_cfg_pkg::cfg_width-1:0] w;
    w = '0;
    w[kd_cfg_pkg::cfg_label_lsb +: kd_tree_pkg::label_width] = 8'(label);
    return w;
  endfunction

  // Walks the model tree where below the median goes left and a tie or more goes right
  function automatic logic [kd_tree_pkg::path_width-1:0] model_leaf(
    input logic [kd_tree_pkg::patch_width-1:0] patch);
    int                                         idx;
    int                                         d;
    logic signed [kd_tree_pkg::coord_width-1:0] coord;
    logic        [kd_tree_pkg::path_width-1:0]  leaf;
    idx = 0;
    for (int lvl = 0; lvl < kd_tree_pkg::tree_depth; lvl++) begin
      d     = int'(model_dim[lvl][idx]);
      coord = '0; // Unused dimension codes read as zero
      if (d < kd_tree_pkg::num_dims) begin
        coord = patch[d*kd_tree_pkg::coord_width +: kd_tree_pkg::coord_width];
      end
      // First branch ends up as the MSB
      idx = idx * 2 + ((coord < model_median[lvl][idx]) ? 0 : 1);
    end
    leaf = idx[kd_tree_pkg::path_width-1:0];
    return leaf;
  endfunction

  task automatic reset_model();
    for (int l = 0; l < kd_tree_pkg::tree_depth; l++) begin
      for (int n = 0; n < 4; n++) begin
        model_dim[l][n]    = kd_tree_pkg::dim_invalid;
        model_median[l][n] = '0;
      end
    end
    for (int i = 0; i < kd_tree_pkg::num_leaves; i++) model_label[i] = '0;
  endtask

  task automatic fill_tables();
    cfg_table[0]  = '{2'd0, 3'd0, node_word(0, 0)};     // Root splits on the sign of dim 0
    cfg_table[1]  = '{2'd1, 3'd0, node_word(1, 100)};
    cfg_table[2]  = '{2'd1, 3'd1, node_word(2, -50)};
    cfg_table[3]  = '{2'd2, 3'd0, node_word(3, 200)};
    cfg_table[4]  = '{2'd2, 3'd1, node_word(4, -300)};
    cfg_table[5]  = '{2'd2, 3'd2, node_word(0, 500)};
    cfg_table[6]  = '{2'd2, 3'd3, node_word(1, -1)};
    for (int i = 0; i < kd_tree_pkg::num_leaves; i++) begin
      cfg_table[7+i] = '{kd_cfg_pkg::leaf_level, 3'(i), leaf_word(8'h31 + 8'(i * 17))};
    end
    query_table[0] = '{make_patch(0, 0, 0, 0, 0), 8'h10};            // Zero meets median zero and goes right
    query_table[1] = '{make_patch(-1, 100, 0, 0, -300), 8'h11};      // Two ties on the left side
    query_table[2] = '{make_patch(-1, 99, 0, 200, 0), 8'h12};
    query_table[3] = '{make_patch(-1, 99, 0, 199, 0), 8'h13};
    query_table[4] = '{make_patch(5, 0, -51, 0, 0), 8'h14};
    query_table[5] = '{make_patch(500, 0, -51, 0, 0), 8'h15};        // Equal to the node median
    query_table[6] = '{make_patch(-1024, 1023, 0, 0, 1023), 8'h16};  // Extremes of the signed range
    query_table[7] = '{make_patch(1023, 0, -1024, 0, 0), 8'h17};
    query_table[8] = '{make_patch(7, -2, -50, 0, 0), 8'h18};         // Negative coordinate, negative median
    query_table[9] = '{make_patch(-600, -5, 0, 0, -301), 8'h19};
  endtask

  // Samples results 1 ns after the edge, then releases the strobes
  task automatic next_cycle();
    expected_t exp;
    @(posedge clk);
    #1;
    cycle_count++;
    if (result_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("result_valid was raised with no query in flight");
      end else begin
        exp = exp_q.pop_front();
        compare("result cycle", 64'(cycle_count), 64'(exp.cycle)); // Exactly four cycles of latency
        compare("result_leaf", 64'(result_leaf), 64'(exp.leaf));
        compare("result_label", 64'(result_label), 64'(exp.label));
        compare("result_tag", 64'(result_tag), 64'(exp.tag));
      end
    end else if (exp_q.size() != 0 && exp_q[0].cycle == cycle_count) begin
      abort_run("no result arrived four cycles after its query");
    end
    cfg_wen     = 1'b0;
    query_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) next_cycle();
  endtask

  task automatic write_cfg(input cfg_entry_t e);
    next_cycle();
    cfg_wen   = 1'b1;
    cfg_level = e.level;
    cfg_addr  = e.addr;
    cfg_wdata = e.word;
    if (e.level == kd_cfg_pkg::leaf_level) begin // Keep the model in step with the DUT
      model_label[e.addr] = e.word[kd_cfg_pkg::cfg_label_lsb +: kd_tree_pkg::label_width];
    end else begin
      model_dim[e.level][e.addr]    = e.word[kd_cfg_pkg::cfg_dim_lsb +: kd_tree_pkg::dim_width];
      model_median[e.level][e.addr] = e.word[kd_cfg_pkg::cfg_median_lsb +: kd_tree_pkg::coord_width];
    end
  endtask

  task automatic send_query(input logic [kd_tree_pkg::patch_width-1:0] patch,
                            input logic [kd_tree_pkg::tag_width-1:0] tag,
                            input logic [kd_tree_pkg::path_width-1:0] leaf,
                            input logic [kd_tree_pkg::label_width-1:0] label);
    next_cycle();
    query_valid = 1'b1;
    query_patch = patch;
    query_tag   = tag;
    exp_q.push_back(expected_t'{leaf, label, tag, 32'(cycle_count + 4)});
  endtask

  task automatic send_modelled(input logic [kd_tree_pkg::patch_width-1:0] patch,
                               input logic [kd_tree_pkg::tag_width-1:0] tag);
    logic [kd_tree_pkg::path_width-1:0] leaf;
    leaf = model_leaf(patch);
    send_query(patch, tag, leaf, model_label[leaf]);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= drain_limit) begin
        abort_run("no result arrived for a pending query before the timeout");
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  initial begin
    seed        = 58775;
    rst_n       = 1'b0;
    cfg_wen     = 1'b0;
    cfg_level   = '0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    query_valid = 1'b0;
    query_patch = '0;
    query_tag   = '0;
    reset_model();
    fill_tables();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle cycles must stay quiet, then every unprogrammed node sends queries right to leaf 7
    idle(8);
    for (int i = 0; i < 3; i++) send_query(random_patch(), 8'(8'he0 + i), 3'd7, 8'd0);
    drain();

    for (int i = 0; i < num_cfg; i++) write_cfg(cfg_table[i]);
    idle(2);

    // Single queries with gaps
    for (int i = 0; i < num_queries; i++) begin
      send_modelled(query_table[i].patch, query_table[i].tag);
      drain();
      idle(3);
    end

    // Same table back to back, one query per cycle
    for (int i = 0; i < num_queries; i++) send_modelled(query_table[i].patch, query_table[i].tag);
    drain();

    for (int i = 0; i < 200; i++) begin
      idle($random(seed) & 3); // Random gap of zero to three cycles
      send_modelled(random_patch(), 8'(i));
    end
    drain();

    // Reprogram one node and two leaves on an empty pipeline
    write_cfg(cfg_entry_t'{2'd1, 3'd1, node_word(3, 42)});
    write_cfg(cfg_entry_t'{kd_cfg_pkg::leaf_level, 3'd2, leaf_word(8'hc3)});
    write_cfg(cfg_entry_t'{kd_cfg_pkg::leaf_level, 3'd6, leaf_word(8'h5e)});
    idle(2);
    for (int i = 0; i < num_queries; i++) begin
      send_modelled(query_table[i].patch, 8'(query_table[i].tag + 8'h80));
    end
    for (int i = 0; i < 40; i++) send_modelled(random_patch(), 8'(8'ha0 + i));
    drain();
    idle(4);

    if (exp_q.size() != 0) begin
      abort_run("expected results were still pending at the end of the run");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: sources.f
src/kd_tree_pkg.sv
src/kd_cfg_pkg.sv
src/kd_query_if.sv
src/kd_cfg_if.sv
src/internal_node.sv
src/kd_level.sv
src/leaf_table.sv
src/kd_tree_top.sv
test/kd_tree_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the KD-tree testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    -f sources.f \
    --top-module kd_tree_tb \
    -Mdir obj_dir \
    -o kd_tree_sim > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/kd_tree_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
